// ==== Bender.yml ====
package:
  name: dl11

sources:
  - include_dirs:
      - rtl
    files:
      - rtl/dl11_pkg.sv
      - rtl/dl11_brg.sv
      - rtl/dl11_uart_tx.sv
      - rtl/dl11_uart_rx.sv
      - rtl/dl11_regs.sv
      - rtl/dl11_top.sv
  - target: test
    include_dirs:
      - rtl
    files:
      - tb/dl11_clkgen.sv
      - tb/dl11_chk.sv
      - tb/dl11_tb.sv

// ==== rtl/dl11_brg.sv ====
/*
 * DL11 baud rate generator
 * single-cycle enable ticks for the bit rate and the 16x sample rate
 */
`timescale 1ns/1ns
`default_nettype none

`include "dl11_cfg.svh"

module dl11_brg
(
   input  logic clk,
   input  logic reset,
   output logic bit_tick,
   output logic sample_tick
);

   localparam int BIT_DIV    = `DL11_CLK_PER_BIT;
   localparam int SAMPLE_DIV = BIT_DIV / 16;
   localparam int CW         = $clog2(BIT_DIV);

   logic [CW-1:0] bit_cnt;
   logic [CW-1:0] sample_cnt;

   // both counters wrap on their own tick
   always_ff @(posedge clk)
   begin
      if (reset)
      begin
         bit_cnt    <= '0;
         sample_cnt <= '0;
      end
      else
      begin
         bit_cnt    <= bit_tick ? '0 : bit_cnt + 1'b1;
         sample_cnt <= sample_tick ? '0 : sample_cnt + 1'b1;
      end
   end

   assign bit_tick    = (bit_cnt == CW'(BIT_DIV - 1));
   assign sample_tick = (sample_cnt == CW'(SAMPLE_DIV - 1));

endmodule

`default_nettype wire

// ==== rtl/dl11_cfg.svh ====
/*
 * DL11 serial line unit constants
 * I/O page register offsets, interrupt vectors and the baud divisor
 */
`ifndef DL11_CFG_SVH
`define DL11_CFG_SVH

// register offsets within the I/O page
`define DL11_RCSR 13'o17560
`define DL11_RBUF 13'o17562
`define DL11_XCSR 13'o17564
`define DL11_XBUF 13'o17566

// fixed interrupt vectors
`define DL11_RX_VECTOR 8'o060
`define DL11_TX_VECTOR 8'o064

// clk cycles per serial bit
// must be a multiple of 16 for the receive sampler
`define DL11_CLK_PER_BIT 32

`endif

// ==== rtl/dl11_pkg.sv ====
/*
 * DL11 serial line unit types
 * I/O page request bundle and the state encodings of all FSMs
 */
`default_nettype none

package dl11_pkg;

   // one I/O page cycle from the CPU side
   typedef struct packed {
      logic [12:0] addr;
      logic [15:0] wdata;
      logic        rd;
      logic        wr;
   } iopage_req_t;

   // transmit handoff between register block and transmitter
   typedef enum logic [1:0] {
      TTO_IDLE  = 2'd0,
      TTO_LOAD  = 2'd1,
      TTO_ACK   = 2'd2,
      TTO_DRAIN = 2'd3
   } tto_state_t;

   // receive handoff between receiver and register block
   typedef enum logic [1:0] {
      TTI_IDLE   = 2'd0,
      TTI_UNLOAD = 2'd1,
      TTI_ACK    = 2'd2,
      TTI_FULL   = 2'd3
   } tti_state_t;

   typedef enum logic [2:0] {
      RX_IDLE  = 3'd0,
      RX_START = 3'd1,
      RX_DATA  = 3'd2,
      RX_STOP  = 3'd3,
      RX_HOLD  = 3'd4
   } rx_state_t;

   typedef enum logic {
      TX_IDLE  = 1'b0,
      TX_SHIFT = 1'b1
   } tx_state_t;

endpackage

`default_nettype wire

// ==== rtl/dl11_regs.sv ====
/*
 * DL11 I/O page register block
 * RCSR, RBUF, XCSR and XBUF with the TTI/TTO handoff FSMs
 * and the interrupt level and vector
 */
`timescale 1ns/1ns
`default_nettype none

`include "dl11_cfg.svh"

module dl11_regs
   import dl11_pkg::*;
(
   input  logic        clk,
   input  logic        reset,
   input  iopage_req_t iopage,
   output logic [15:0] data_out,
   output logic        decode,
   output logic        interrupt,
   output logic [7:0]  vector,
   output logic        ld_tx_req,
   input  logic        ld_tx_ack,
   input  logic        tx_empty,
   output logic [7:0]  tx_byte,
   output logic        uld_rx_req,
   input  logic        uld_rx_ack,
   input  logic        rx_empty,
   input  logic [7:0]  rx_data
);

   tto_state_t tto_state;
   tto_state_t tto_next;
   tti_state_t tti_state;
   tti_state_t tti_next;

   logic       sel_rcsr;
   logic       sel_rbuf;
   logic       sel_xcsr;
   logic       sel_xbuf;
   logic       rx_int_enable;
   logic       tx_int_enable;
   logic [7:0] xbuf;
   logic [7:0] rbuf;
   logic       tto_ready;
   logic       tti_done;
   logic       xbuf_wr;
   logic       rbuf_rd;
   logic       rx_int;
   logic       tx_int;

   // address decode
   assign sel_rcsr = (iopage.addr == `DL11_RCSR);
   assign sel_rbuf = (iopage.addr == `DL11_RBUF);
   assign sel_xcsr = (iopage.addr == `DL11_XCSR);
   assign sel_xbuf = (iopage.addr == `DL11_XBUF);
   assign decode   = sel_rcsr | sel_rbuf | sel_xcsr | sel_xbuf;

   assign xbuf_wr = iopage.wr && sel_xbuf;
   assign rbuf_rd = iopage.rd && sel_rbuf;

   // ready bits come straight from the handoff FSMs
   assign tto_ready = (tto_state == TTO_IDLE);
   assign tti_done  = (tti_state == TTI_FULL);

   // read mux
   always_comb
   begin
      data_out = 16'h0000;
      if (iopage.rd)
      begin
         if (sel_rcsr)
            data_out = {8'h00, tti_done, rx_int_enable, 6'b000000};
         else if (sel_rbuf)
            data_out = {8'h00, rbuf};
         else if (sel_xcsr)
            data_out = {8'h00, tto_ready, tx_int_enable, 6'b000000};
         else if (sel_xbuf)
            data_out = {8'h00, xbuf};
      end
   end

   // CSR and XBUF writes, RCSR and RBUF data bits are read only
   always_ff @(posedge clk)
   begin
      if (reset)
      begin
         rx_int_enable <= 1'b0;
         tx_int_enable <= 1'b0;
         xbuf          <= 8'h00;
      end
      else if (iopage.wr)
      begin
         if (sel_rcsr)
            rx_int_enable <= iopage.wdata[6];
         if (sel_xcsr)
            tx_int_enable <= iopage.wdata[6];
         if (sel_xbuf)
            xbuf <= iopage.wdata[7:0];
      end
   end

   assign tx_byte = xbuf;

   // TTO holds the request until the transmitter acks,
   // then waits for the frame to leave before going ready again
   always_comb
   begin
      tto_next = tto_state;
      case (tto_state)
         TTO_IDLE:
            if (xbuf_wr)
               tto_next = TTO_LOAD;
         TTO_LOAD:
            if (ld_tx_ack)
               tto_next = TTO_ACK;
         TTO_ACK:
            if (!ld_tx_ack)
               tto_next = TTO_DRAIN;
         TTO_DRAIN:
            if (tx_empty)
               tto_next = TTO_IDLE;
      endcase
   end

   // TTI pulls the byte out of the receiver and stays full until RBUF is read
   always_comb
   begin
      tti_next = tti_state;
      case (tti_state)
         TTI_IDLE:
            if (!rx_empty)
               tti_next = TTI_UNLOAD;
         TTI_UNLOAD:
            if (uld_rx_ack)
               tti_next = TTI_ACK;
         TTI_ACK:
            if (!uld_rx_ack)
               tti_next = TTI_FULL;
         TTI_FULL:
            if (rbuf_rd)
               tti_next = TTI_IDLE;
      endcase
   end

   always_ff @(posedge clk)
   begin
      if (reset)
      begin
         tto_state <= TTO_IDLE;
         tti_state <= TTI_IDLE;
      end
      else
      begin
         tto_state <= tto_next;
         tti_state <= tti_next;
      end
   end

   assign ld_tx_req  = (tto_state == TTO_LOAD);
   assign uld_rx_req = (tti_state == TTI_UNLOAD);

   // capture the byte while the receiver acks the unload
   always_ff @(posedge clk)
   begin
      if (reset)
         rbuf <= 8'h00;
      else if (tti_state == TTI_UNLOAD && uld_rx_ack)
         rbuf <= rx_data;
   end

   // interrupt level, receive has priority for the vector
   assign rx_int = rx_int_enable && tti_done;
   assign tx_int = tx_int_enable && tto_ready;

   always_ff @(posedge clk)
   begin
      if (reset)
         interrupt <= 1'b0;
      else
         interrupt <= rx_int || tx_int;
   end

   assign vector = rx_int ? `DL11_RX_VECTOR :
                   tx_int ? `DL11_TX_VECTOR :
                   8'h00;

endmodule

`default_nettype wire

// ==== rtl/dl11_top.sv ====
/*
 * DL11 serial line unit
 * baud generator, UART halves and the I/O page register block
 */
`timescale 1ns/1ns
`default_nettype none

module dl11_top
   import dl11_pkg::*;
(
   input  logic        clk,
   input  logic        reset,
   input  iopage_req_t iopage,
   output logic [15:0] data_out,
   output logic        decode,
   output logic        interrupt,
   output logic [7:0]  vector,
   output logic        rs232_tx,
   input  logic        rs232_rx
);

   logic       bit_tick;
   logic       sample_tick;
   logic       ld_tx_req;
   logic       ld_tx_ack;
   logic       tx_empty;
   logic [7:0] tx_byte;
   logic       uld_rx_req;
   logic       uld_rx_ack;
   logic       rx_empty;
   logic [7:0] rx_data;

   dl11_brg u_brg
   (
      .clk         (clk),
      .reset       (reset),
      .bit_tick    (bit_tick),
      .sample_tick (sample_tick)
   );

   dl11_uart_rx u_rx
   (
      .clk         (clk),
      .reset       (reset),
      .sample_tick (sample_tick),
      .rx_in       (rs232_rx),
      .uld_rx_req  (uld_rx_req),
      .uld_rx_ack  (uld_rx_ack),
      .rx_data     (rx_data),
      .rx_empty    (rx_empty)
   );

   dl11_regs u_regs
   (
      .clk        (clk),
      .reset      (reset),
      .iopage     (iopage),
      .data_out   (data_out),
      .decode     (decode),
      .interrupt  (interrupt),
      .vector     (vector),
      .ld_tx_req  (ld_tx_req),
      .ld_tx_ack  (ld_tx_ack),
      .tx_empty   (tx_empty),
      .tx_byte    (tx_byte),
      .uld_rx_req (uld_rx_req),
      .uld_rx_ack (uld_rx_ack),
      .rx_empty   (rx_empty),
      .rx_data    (rx_data)
   );

   dl11_uart_tx u_tx
   (
      .clk       (clk),
      .reset     (reset),
      .bit_tick  (bit_tick),
      .ld_tx_req (ld_tx_req),
      .tx_data   (tx_byte),
      .ld_tx_ack (ld_tx_ack),
      .tx_empty  (tx_empty),
      .tx_out    (rs232_tx)
   );

endmodule

`default_nettype wire

// ==== rtl/dl11_uart_rx.sv ====
/*
 * DL11 UART receiver
 * 16x oversampled async receiver holding one byte for the unload handshake
 */
`timescale 1ns/1ns
`default_nettype none

module dl11_uart_rx
   import dl11_pkg::*;
(
   input  logic       clk,
   input  logic       reset,
   input  logic       sample_tick,
   input  logic       rx_in,
   input  logic       uld_rx_req,
   output logic       uld_rx_ack,
   output logic [7:0] rx_data,
   output logic       rx_empty
);

   rx_state_t  rx_state;
   logic [1:0] rx_sync;
   logic       rx_line;
   logic       rx_prev;
   logic [3:0] sample_cnt;
   logic [2:0] bit_idx;
   logic [7:0] shreg;
   logic       bit_done;

   // two-flop synchronizer for the async line
   always_ff @(posedge clk)
   begin
      if (reset)
         rx_sync <= 2'b11;
      else
         rx_sync <= {rx_sync[0], rx_in};
   end

   assign rx_line  = rx_sync[1];
   assign bit_done = sample_tick && (sample_cnt == 4'd15);

   always_ff @(posedge clk)
   begin
      if (reset)
      begin
         rx_state   <= RX_IDLE;
         rx_prev    <= 1'b1;
         sample_cnt <= 4'd0;
         bit_idx    <= 3'd0;
         rx_empty   <= 1'b1;
         uld_rx_ack <= 1'b0;
      end
      else
      begin
         if (sample_tick)
            rx_prev <= rx_line;

         case (rx_state)
            RX_IDLE:
            begin
               // falling edge starts the hunt
               if (sample_tick && rx_prev && !rx_line)
               begin
                  sample_cnt <= 4'd0;
                  rx_state   <= RX_START;
               end
            end
            RX_START:
            begin
               if (sample_tick)
               begin
                  // mid start bit, still low or it was a glitch
                  if (sample_cnt == 4'd7)
                  begin
                     sample_cnt <= 4'd0;
                     bit_idx    <= 3'd0;
                     rx_state   <= rx_line ? RX_IDLE : RX_DATA;
                  end
                  else
                     sample_cnt <= sample_cnt + 4'd1;
               end
            end
            RX_DATA:
            begin
               if (sample_tick)
                  sample_cnt <= sample_cnt + 4'd1;
               if (bit_done)
               begin
                  bit_idx <= bit_idx + 3'd1;
                  if (bit_idx == 3'd7)
                     rx_state <= RX_STOP;
               end
            end
            RX_STOP:
            begin
               if (sample_tick)
                  sample_cnt <= sample_cnt + 4'd1;
               // a low stop bit drops the frame
               if (bit_done)
               begin
                  if (rx_line)
                  begin
                     rx_empty <= 1'b0;
                     rx_state <= RX_HOLD;
                  end
                  else
                     rx_state <= RX_IDLE;
               end
            end
            RX_HOLD:
            begin
               // frames arriving here are lost
               if (uld_rx_req && !uld_rx_ack)
                  uld_rx_ack <= 1'b1;
               else if (uld_rx_ack && !uld_rx_req)
               begin
                  uld_rx_ack <= 1'b0;
                  rx_empty   <= 1'b1;
                  rx_state   <= RX_IDLE;
               end
            end
            default:
               rx_state <= RX_IDLE;
         endcase
      end
   end

   // data path, LSB arrives first
   always_ff @(posedge clk)
   begin
      if (rx_state == RX_DATA && bit_done)
         shreg <= {rx_line, shreg[7:1]};
      if (rx_state == RX_STOP && bit_done && rx_line)
         rx_data <= shreg;
   end

endmodule

`default_nettype wire

// ==== rtl/dl11_uart_tx.sv ====
/*
 * DL11 UART transmitter
 * takes a byte over the load handshake and sends start, 8 data, stop
 */
`timescale 1ns/1ns
`default_nettype none

module dl11_uart_tx
   import dl11_pkg::*;
(
   input  logic       clk,
   input  logic       reset,
   input  logic       bit_tick,
   input  logic       ld_tx_req,
   input  logic [7:0] tx_data,
   output logic       ld_tx_ack,
   output logic       tx_empty,
   output logic       tx_out
);

   tx_state_t  tx_state;
   logic [9:0] frame;
   logic [3:0] bit_cnt;
   logic       load;

   // accept a new byte only when idle and the previous handshake is closed
   assign load = (tx_state == TX_IDLE) && ld_tx_req && !ld_tx_ack;

   always_ff @(posedge clk)
   begin
      if (reset)
      begin
         tx_state  <= TX_IDLE;
         bit_cnt   <= 4'd0;
         ld_tx_ack <= 1'b0;
         tx_out    <= 1'b1;
      end
      else
      begin
         // ack stays up until the request drops
         if (load)
            ld_tx_ack <= 1'b1;
         else if (ld_tx_ack && !ld_tx_req)
            ld_tx_ack <= 1'b0;

         case (tx_state)
            TX_IDLE:
            begin
               if (load)
               begin
                  bit_cnt  <= 4'd0;
                  tx_state <= TX_SHIFT;
               end
            end
            TX_SHIFT:
            begin
               if (bit_tick)
               begin
                  // tick 11 ends the stop bit
                  if (bit_cnt == 4'd10)
                  begin
                     tx_out   <= 1'b1;
                     tx_state <= TX_IDLE;
                  end
                  else
                  begin
                     tx_out  <= frame[0];
                     bit_cnt <= bit_cnt + 4'd1;
                  end
               end
            end
         endcase
      end
   end

   // stop bit, data LSB first, start bit in the low position
   always_ff @(posedge clk)
   begin
      if (load)
         frame <= {1'b1, tx_data, 1'b0};
      else if (tx_state == TX_SHIFT && bit_tick)
         frame <= {1'b1, frame[9:1]};
   end

   assign tx_empty = (tx_state == TX_IDLE);

endmodule

`default_nettype wire

// ==== tb/dl11_chk.sv ====
/*
 * DL11 register block checker
 * bus and handshake rules, bound into dl11_regs
 */
`timescale 1ns/1ns
`default_nettype none

module dl11_chk
(
   input logic        clk,
   input logic        reset,
   input logic [15:0] data_out,
   input logic        decode,
   input logic        interrupt,
   input logic [7:0]  vector,
   input logic        ld_tx_req,
   input logic        ld_tx_ack,
   input logic        uld_rx_req,
   input logic        uld_rx_ack
);

   int unsigned failures = 0;

   // an address outside the block must leave the bus at zero
   a_idle_bus: assert property (@(posedge clk) disable iff (reset)
      !decode |-> data_out == 16'h0000)
   else
   begin
      failures++;
      $error("data_out nonzero while decode is low");
   end

   // interrupt lags the conditions by one clk, so compare with last cycle's vector
   a_int_vector: assert property (@(posedge clk) disable iff (reset)
      interrupt |-> $past(vector) != 8'h00)
   else
   begin
      failures++;
      $error("interrupt high without a vector");
   end

   a_tx_handshake: assert property (@(posedge clk) disable iff (reset)
      $rose(ld_tx_req) |-> !ld_tx_ack)
   else
   begin
      failures++;
      $error("ld_tx_req raised while ld_tx_ack still high");
   end

   a_rx_handshake: assert property (@(posedge clk) disable iff (reset)
      $rose(uld_rx_req) |-> !uld_rx_ack)
   else
   begin
      failures++;
      $error("uld_rx_req raised while uld_rx_ack still high");
   end

endmodule

bind dl11_regs dl11_chk u_chk
(
   .clk        (clk),
   .reset      (reset),
   .data_out   (data_out),
   .decode     (decode),
   .interrupt  (interrupt),
   .vector     (vector),
   .ld_tx_req  (ld_tx_req),
   .ld_tx_ack  (ld_tx_ack),
   .uld_rx_req (uld_rx_req),
   .uld_rx_ack (uld_rx_ack)
);

`default_nettype wire

// ==== tb/dl11_clkgen.sv ====
/*
 * DL11 testbench clock and reset
 * 10 ns clock, synchronous reset held for the first 10 cycles
 */
`timescale 1ns/1ns
`default_nettype none

module dl11_clkgen
(
   output logic clk,
   output logic reset
);

   always
   begin
      clk = 1'b0;
      #5;
      clk = 1'b1;
      #5;
   end

   initial
   begin
      reset = 1'b1;
      repeat (10) @(posedge clk);
      reset <= 1'b0;
   end

endmodule

`default_nettype wire

// ==== tb/dl11_tb.sv ====
/*
 * DL11 serial line unit testbench
 * table-driven I/O page accesses with a serial line model on both pins
 */
`timescale 1ns/1ns
`default_nettype none

`include "dl11_cfg.svh"

module dl11_tb
   import dl11_pkg::*;
();

   localparam int CPB     = `DL11_CLK_PER_BIT;
   localparam int TIMEOUT = 30 * CPB;
   localparam int NSTIM   = 6;

   typedef struct packed {
      logic [7:0] data;
      logic       rx_ie;
      logic       tx_ie;
   } stim_t;

   logic        clk;
   logic        reset;
   iopage_req_t iopage;
   logic [15:0] data_out;
   logic        decode;
   logic        interrupt;
   logic [7:0]  vector;
   logic        rs232_tx;
   logic        rs232_rx;

   stim_t       stim [NSTIM];
   int          errors;
   int          checks;
   int          tests_run;
   int          tests_failed;

   dl11_clkgen u_clkgen
   (
      .clk   (clk),
      .reset (reset)
   );

   dl11_top UUT
   (
      .clk       (clk),
      .reset     (reset),
      .iopage    (iopage),
      .data_out  (data_out),
      .decode    (decode),
      .interrupt (interrupt),
      .vector    (vector),
      .rs232_tx  (rs232_tx),
      .rs232_rx  (rs232_rx)
   );

   // CSR layout: ready at bit 7, interrupt enable at bit 6
   function automatic logic [15:0] csr_word(input logic ready, input logic ie);
      return {8'h00, ready, ie, 6'b000000};
   endfunction

   // receive wins over transmit
   function automatic logic [7:0] expected_vector(input logic rx_cond, input logic tx_cond);
      if (rx_cond)
         return `DL11_RX_VECTOR;
      else if (tx_cond)
         return `DL11_TX_VECTOR;
      return 8'h00;
   endfunction

   task automatic check_value(input string name, input logic [15:0] expected,
                              input logic [15:0] actual);
      checks++;
      assert (actual === expected)
      else
      begin
         $display("[FAIL] %0t ns %s expected %06o got %06o", $time, name, expected, actual);
         errors++;
      end
   endtask

   task automatic report_timeout(input string what);
      $display("timeout at %0t ns while waiting for %s", $time, what);
      errors++;
   endtask

   task automatic finish_test(input string name, input int errors_before);
      tests_run++;
      if (errors == errors_before)
         $display("test %s: passed", name);
      else
      begin
         tests_failed++;
         $display("test %s: failed with %0d errors", name, errors - errors_before);
      end
   endtask

   task automatic io_write(input logic [12:0] addr, input logic [15:0] wdata);
      @(posedge clk);
      iopage <= '{addr: addr, wdata: wdata, rd: 1'b0, wr: 1'b1};
      @(posedge clk);
      iopage <= '0;
   endtask

   // data_out and decode are combinational, so take them mid-cycle
   task automatic io_read(input logic [12:0] addr, output logic [15:0] rdata,
                          output logic dec);
      @(posedge clk);
      iopage <= '{addr: addr, wdata: 16'h0000, rd: 1'b1, wr: 1'b0};
      @(negedge clk);
      rdata = data_out;
      dec   = decode;
      @(posedge clk);
      iopage <= '0;
   endtask

   task automatic wait_ready(input logic [12:0] addr, input string what);
      logic [15:0] d;
      logic        dec;
      int          n;
      n = 0;
      d = 16'h0000;
      while (!d[7] && n < TIMEOUT)
      begin
         io_read(addr, d, dec);
         n += 2;
      end
      if (!d[7])
         report_timeout(what);
   endtask

   task automatic wait_reset;
      int n;
      n = 0;
      while (reset !== 1'b0 && n < TIMEOUT)
      begin
         @(negedge clk);
         n++;
      end
      if (reset !== 1'b0)
         report_timeout("reset release");
   endtask

   // start bit, data LSB first, stop bit
   task automatic send_frame(input logic [7:0] data);
      logic [9:0] frame;
      int         i;
      frame = {1'b1, data, 1'b0};
      for (i = 0; i < 10; i++)
      begin
         @(posedge clk);
         rs232_rx <= frame[i];
         repeat (CPB - 1) @(posedge clk);
      end
   endtask

   task automatic decode_frame(output logic [7:0] data, output logic start_bit,
                               output logic stop_bit, output logic found);
      int n;
      int i;
      n         = 0;
      data      = 8'h00;
      start_bit = 1'b1;
      stop_bit  = 1'b0;
      found     = 1'b0;
      while (rs232_tx !== 1'b0 && n < TIMEOUT)
      begin
         @(negedge clk);
         n++;
      end
      if (rs232_tx === 1'b0)
      begin
         found = 1'b1;
         // centre of the start bit, then one bit time per sample
         repeat (CPB / 2) @(negedge clk);
         start_bit = rs232_tx;
         for (i = 0; i < 8; i++)
         begin
            repeat (CPB) @(negedge clk);
            data[i] = rs232_tx;
         end
         repeat (CPB) @(negedge clk);
         stop_bit = rs232_tx;
      end
   endtask

   task automatic load_stim;
      stim[0] = '{data: 8'h55, rx_ie: 1'b0, tx_ie: 1'b0};
      stim[1] = '{data: 8'ha3, rx_ie: 1'b1, tx_ie: 1'b0};
      stim[2] = '{data: 8'h0f, rx_ie: 1'b0, tx_ie: 1'b1};
      stim[3] = '{data: 8'hc8, rx_ie: 1'b1, tx_ie: 1'b1};
      stim[4] = '{data: 8'($urandom), rx_ie: 1'b1, tx_ie: 1'b0};
      stim[5] = '{data: 8'($urandom), rx_ie: 1'b1, tx_ie: 1'b1};
   endtask

   task automatic test_reset;
      logic [15:0] d;
      logic        dec;
      @(negedge clk);
      check_value("interrupt", 16'd0, interrupt);
      check_value("vector", 16'd0, vector);
      check_value("rs232_tx", 16'd1, rs232_tx);
      io_read(`DL11_RCSR, d, dec);
      check_value("RCSR", 16'o000000, d);
      io_read(`DL11_XCSR, d, dec);
      check_value("XCSR", 16'o000200, d);
   endtask

   task automatic run_entry(input stim_t s);
      logic [15:0] d;
      logic        dec;
      logic [7:0]  got;
      logic        start_bit;
      logic        stop_bit;
      logic        found;
      io_write(`DL11_RCSR, csr_word(1'b0, s.rx_ie));
      io_write(`DL11_XCSR, csr_word(1'b0, s.tx_ie));
      io_read(`DL11_XCSR, d, dec);
      check_value("XCSR", csr_word(1'b1, s.tx_ie), d);
      @(negedge clk);
      check_value("interrupt", s.tx_ie, interrupt);
      check_value("vector", expected_vector(1'b0, s.tx_ie), vector);

      // transmit, with the line model listening from before the write
      fork
         decode_frame(got, start_bit, stop_bit, found);
         begin
            io_write(`DL11_XBUF, {8'h00, s.data});
            io_read(`DL11_XCSR, d, dec);
            check_value("XCSR", csr_word(1'b0, s.tx_ie), d);
         end
      join
      if (!found)
         report_timeout("start bit on rs232_tx");
      else
      begin
         check_value("rs232_tx start bit", 16'd0, start_bit);
         check_value("rs232_tx data", s.data, got);
         check_value("rs232_tx stop bit", 16'd1, stop_bit);
      end
      wait_ready(`DL11_XCSR, "XCSR ready");

      // receive
      send_frame(s.data);
      wait_ready(`DL11_RCSR, "RCSR ready");
      @(negedge clk);
      if (s.rx_ie)
      begin
         check_value("interrupt", 16'd1, interrupt);
         check_value("vector", expected_vector(1'b1, s.tx_ie), vector);
      end
      io_read(`DL11_RBUF, d, dec);
      check_value("RBUF", s.data, d);
      io_read(`DL11_RCSR, d, dec);
      check_value("RCSR", csr_word(1'b0, s.rx_ie), d);
      @(negedge clk);
      check_value("interrupt", s.tx_ie, interrupt);
      check_value("vector", expected_vector(1'b0, s.tx_ie), vector);
   endtask

   task automatic test_decode;
      logic [15:0] rcsr_before;
      logic [15:0] xcsr_before;
      logic [15:0] xbuf_before;
      logic [15:0] d;
      logic        dec;
      io_read(`DL11_RCSR, rcsr_before, dec);
      check_value("decode at RCSR", 16'd1, dec);
      io_read(`DL11_XCSR, xcsr_before, dec);
      check_value("decode at XCSR", 16'd1, dec);
      io_read(`DL11_XBUF, xbuf_before, dec);
      check_value("decode at XBUF", 16'd1, dec);
      io_read(13'o17556, d, dec);
      check_value("decode at 17556", 16'd0, dec);
      check_value("data_out at 17556", 16'd0, d);
      io_read(13'o17570, d, dec);
      check_value("decode at 17570", 16'd0, dec);
      check_value("data_out at 17570", 16'd0, d);
      // both enables are set here, so zeros would show up in a register
      io_write(13'o17556, 16'o000000);
      io_write(13'o17570, 16'o000000);
      io_read(`DL11_RCSR, d, dec);
      check_value("RCSR", rcsr_before, d);
      io_read(`DL11_XCSR, d, dec);
      check_value("XCSR", xcsr_before, d);
      io_read(`DL11_XBUF, d, dec);
      check_value("XBUF", xbuf_before, d);
   endtask

   initial
   begin
      int          e0;
      int          i;
      int unsigned chk_failures;
      iopage       = '0;
      rs232_rx     = 1'b1;
      errors       = 0;
      checks       = 0;
      tests_run    = 0;
      tests_failed = 0;
      void'($urandom(32'h5dae));
      load_stim();
      wait_reset();

      e0 = errors;
      test_reset();
      finish_test("reset state", e0);

      for (i = 0; i < NSTIM; i++)
      begin
         e0 = errors;
         run_entry(stim[i]);
         finish_test($sformatf("entry %0d byte %03o rx_ie %0d tx_ie %0d", i,
                     stim[i].data, stim[i].rx_ie, stim[i].tx_ie), e0);
      end

      e0 = errors;
      test_decode();
      finish_test("decode", e0);

      chk_failures = UUT.u_regs.u_chk.failures;
      $display("tests %0d, failed %0d, checks %0d, errors %0d, assertion failures %0d",
               tests_run, tests_failed, checks, errors, chk_failures);
      if (errors == 0 && chk_failures == 0)
         $display("ALL TESTS PASSED");
      else
         $display("SOME TESTS FAILED");
      $finish;
   end

endmodule

`default_nettype wire

// ==== verilog.f ====
+incdir+rtl
rtl/dl11_pkg.sv
rtl/dl11_brg.sv
rtl/dl11_uart_tx.sv
rtl/dl11_uart_rx.sv
rtl/dl11_regs.sv
rtl/dl11_top.sv
tb/dl11_clkgen.sv
tb/dl11_chk.sv
tb/dl11_tb.sv
